// ==== sources.f ====
+incdir+source
source/mips_pkg.sv
source/word_mem.sv
source/register_file.sv
source/main_control.sv
source/alu.sv
source/mips_pipeline.sv
dv/mips_tb.sv

// ==== Bender.yml ====
package:
  name: mips_pipeline

sources:
  - include_dirs:
      - source
    files:
      - source/mips_pkg.sv
      - source/word_mem.sv
      - source/register_file.sv
      - source/main_control.sv
      - source/alu.sv
      - source/mips_pipeline.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/mips_tb.sv

// ==== dv/mips_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mips_settings.svh"

module mips_tb;

	import mips_pkg::*;

	logic                     clk;
	logic                     rst;
	logic                     run;
	logic                     load_valid;
	logic                     load_ready;
	logic [`MIPS_IMEM_AW-1:0] load_addr;
	word_t                    load_data;
	logic                     wb_valid;
	reg_idx_t                 wb_reg;
	word_t                    wb_data;
	logic                     st_valid;
	word_t                    st_addr;
	word_t                    st_data;

	word_t    prog [$];
	reg_idx_t exp_wb_reg [$];
	word_t    exp_wb_data [$];
	word_t    exp_st_addr [$];
	word_t    exp_st_data [$];
	word_t    mregs [32] = '{default: '0}; // Model state lives across tests, like the DUT.
	word_t    mmem [int];
	int       end_pc;
	word_t    lcg_state = 32'hb017;
	int       mismatch_errors = 0;
	int       other_errors = 0;
	int       cycle_count = 0;
	int       cycle_limit = 40; // Reset plus slack.

	mips_pipeline dut_i (
		.clk        (clk),
		.rst        (rst),
		.run        (run),
		.load_valid (load_valid),
		.load_ready (load_ready),
		.load_addr  (load_addr),
		.load_data  (load_data),
		.wb_valid   (wb_valid),
		.wb_reg     (wb_reg),
		.wb_data    (wb_data),
		.st_valid   (st_valid),
		.st_addr    (st_addr),
		.st_data    (st_data)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic word_t next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic word_t rtype_word(funct_e fn, int rd, int rs, int rt, int sh);
		return {OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
	endfunction

	function automatic word_t itype_word(opcode_e op, int rt, int rs, int imm);
		return {op, rs[4:0], rt[4:0], imm[15:0]};
	endfunction

	function automatic word_t jump_word(int idx);
		return {OP_J, idx[25:0]};
	endfunction

	function automatic int mem_index(word_t addr);
		return int'(addr[`MIPS_DMEM_AW+1:2]);
	endfunction

	task automatic emit(word_t w);
		prog.push_back(w);
	endtask

	task automatic pad(int n);
		repeat (n) prog.push_back('0); // sll r0, r0, 0.
	endtask

	// Upper half by addi and sll, lower half added with sign extension.
	task automatic emit_const(int rd, word_t value);
		emit(itype_word(OP_ADDI, rd, 0, value[31:16]));
		pad(2);
		emit(rtype_word(FN_SLL, rd, 0, rd, 16));
		pad(2);
		emit(itype_word(OP_ADDI, rd, rd, value[15:0]));
		pad(2);
	endtask

	// Jump to itself with two empty slots; the core parks here.
	task automatic close_program();
		end_pc = prog.size() * 4;
		emit(jump_word(prog.size()));
		pad(2);
	endtask

	task automatic check_ready(logic got, logic expected);
		if (got !== expected) begin
			$display("Mismatch load_ready: got %h, expected %h", got, expected);
			mismatch_errors++;
		end
	endtask

	task automatic check_wb(reg_idx_t got_reg, word_t got_data);
		reg_idx_t er;
		word_t    ed;
		if (exp_wb_reg.size() == 0) begin
			$display("Unexpected write-back to r%0d beyond the end of the program", got_reg);
			other_errors++;
		end else begin
			er = exp_wb_reg.pop_front();
			ed = exp_wb_data.pop_front();
			if (got_reg !== er) begin
				$display("Mismatch wb_reg: got %h, expected %h", got_reg, er);
				mismatch_errors++;
			end
			if (got_data !== ed) begin
				$display("Mismatch wb_data: got %h, expected %h", got_data, ed);
				mismatch_errors++;
			end
		end
	endtask

	task automatic check_st(word_t got_addr, word_t got_data);
		word_t ea;
		word_t ed;
		if (exp_st_addr.size() == 0) begin
			$display("Unexpected store to %h beyond the end of the program", got_addr);
			other_errors++;
		end else begin
			ea = exp_st_addr.pop_front();
			ed = exp_st_data.pop_front();
			if (got_addr !== ea) begin
				$display("Mismatch st_addr: got %h, expected %h", got_addr, ea);
				mismatch_errors++;
			end
			if (got_data !== ed) begin
				$display("Mismatch st_data: got %h, expected %h", got_data, ed);
				mismatch_errors++;
			end
		end
	endtask

	// Outputs come from flops, so the falling edge sees them settled.
	always @(negedge clk) begin
		if (!rst) begin
			if (wb_valid) begin
				if (wb_reg == '0) begin
					$display("Write-back to register zero was reported");
					other_errors++;
				end
				check_wb(wb_reg, wb_data);
			end
			if (st_valid) begin
				check_st(st_addr, st_data);
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("Timeout: tests did not complete within %0d cycles", cycle_limit);
			$display("Errors: %0d mismatches, %0d other failures", mismatch_errors,
				other_errors);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	task automatic record_write(reg_idx_t rd, word_t val);
		if (rd != '0) begin
			mregs[rd] = val;
			exp_wb_reg.push_back(rd);
			exp_wb_data.push_back(val);
		end
	endtask

	// ISA-level model with two jump slots and three branch slots.
	task automatic run_model();
		word_t pc;
		word_t nxt;
		word_t ins;
		word_t a;
		word_t b;
		word_t imm;
		word_t res;
		word_t j_tgt;
		word_t b_tgt;
		int    j_left;
		int    b_left;
		int    steps;
		exp_wb_reg.delete();
		exp_wb_data.delete();
		exp_st_addr.delete();
		exp_st_data.delete();
		pc = '0;
		j_tgt = '0;
		b_tgt = '0;
		j_left = -1;
		b_left = -1;
		steps = 0;
		while (pc != word_t'(end_pc) && steps < 4 * prog.size()) begin
			ins = prog[pc >> 2];
			a = mregs[ins[25:21]];
			b = mregs[ins[20:16]];
			imm = {{16{ins[15]}}, ins[15:0]};
			nxt = pc + 32'd4;
			case (opcode_e'(ins[31:26]))
				OP_RTYPE: begin
					case (funct_e'(ins[5:0]))
						FN_ADD:  res = a + b;
						FN_SUB:  res = a - b;
						FN_AND:  res = a & b;
						FN_OR:   res = a | b;
						FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						FN_SLL:  res = b << ins[10:6];
						FN_SRL:  res = b >> ins[10:6];
						default: res = 'x;
					endcase
					record_write(ins[15:11], res);
				end
				OP_ADDI: record_write(ins[20:16], a + imm);
				OP_LW:   record_write(ins[20:16], mmem[mem_index(a + imm)]);
				OP_SW: begin
					exp_st_addr.push_back(a + imm);
					exp_st_data.push_back(b);
					mmem[mem_index(a + imm)] = b;
				end
				OP_BEQ: begin
					if (a == b) begin
						b_left = 3;
						b_tgt = nxt + (imm << 2);
					end
				end
				OP_J: begin
					j_left = 2;
					j_tgt = {nxt[31:28], ins[25:0], 2'b00};
				end
				default: ;
			endcase
			if (j_left == 0) nxt = j_tgt;
			if (b_left == 0) nxt = b_tgt; // Branch wins over jump.
			if (j_left >= 0) j_left--;
			if (b_left >= 0) b_left--;
			pc = nxt;
			steps++;
		end
		if (pc != word_t'(end_pc)) begin
			$display("Reference model never reached the end of the program");
			other_errors++;
		end
	endtask

	task automatic load_program();
		int i;
		for (i = 0; i < prog.size(); i++) begin
			@(negedge clk);
			load_valid = 1'b1;
			load_addr  = i[`MIPS_IMEM_AW-1:0];
			load_data  = prog[i];
			@(posedge clk);
			while (!load_ready) @(posedge clk);
		end
		@(negedge clk);
		load_valid = 1'b0;
	endtask

	task automatic run_test(string name);
		$display("Running %s, %0d words", name, prog.size());
		cycle_limit += 2 * prog.size() + 20; // Load, run and drain.
		@(negedge clk);
		run = 1'b0;
		load_program();
		run_model();
		@(negedge clk);
		run = 1'b1;
		@(posedge clk);
		check_ready(load_ready, 1'b0);
		while (exp_wb_reg.size() != 0 || exp_st_addr.size() != 0) @(posedge clk);
		repeat (6) @(negedge clk); // Catch late extras.
		run = 1'b0;
		@(posedge clk);
		check_ready(load_ready, 1'b1);
	endtask

	task automatic test_load_port();
		prog.delete();
		@(posedge clk);
		check_ready(load_ready, 1'b1);
		emit(itype_word(OP_ADDI, 1, 0, 'h123));
		emit(itype_word(OP_ADDI, 2, 0, -1));
		pad(2);
		emit(rtype_word(FN_ADD, 3, 1, 2, 0));
		close_program();
		run_test("load port");
	endtask

	task automatic test_rtype();
		prog.delete();
		emit_const(1, next_rand());
		emit_const(2, next_rand());
		emit(rtype_word(FN_ADD, 3, 1, 2, 0));
		emit(rtype_word(FN_SUB, 4, 1, 2, 0));
		emit(rtype_word(FN_AND, 5, 1, 2, 0));
		emit(rtype_word(FN_OR, 6, 1, 2, 0));
		emit(rtype_word(FN_SLT, 7, 1, 2, 0));
		emit(rtype_word(FN_SLT, 8, 2, 1, 0));
		emit(rtype_word(FN_ADD, 0, 1, 2, 0)); // Lost to r0.
		close_program();
		run_test("r-type arithmetic");
	endtask

	task automatic test_imm_shift();
		int s1;
		int s2;
		prog.delete();
		s1 = int'(next_rand() >> 16) % 32;
		s2 = int'(next_rand() >> 16) % 32;
		emit(itype_word(OP_ADDI, 9, 0, -5));
		emit(itype_word(OP_ADDI, 10, 0, -32768));
		emit(itype_word(OP_ADDI, 11, 0, 'h7fff));
		pad(2);
		emit(itype_word(OP_ADDI, 12, 9, -100));
		emit(rtype_word(FN_SLL, 13, 0, 9, s1));
		emit(rtype_word(FN_SRL, 14, 0, 9, s2));
		emit(rtype_word(FN_SRL, 15, 0, 10, 1));
		emit(rtype_word(FN_SLL, 16, 0, 11, 31));
		emit(rtype_word(FN_SRL, 17, 0, 10, 31));
		close_program();
		run_test("immediate and shift");
	endtask

	task automatic test_memory();
		prog.delete();
		emit(itype_word(OP_ADDI, 18, 0, 'h40)); // Base address.
		emit_const(19, next_rand());
		emit(itype_word(OP_SW, 19, 18, 8));
		emit(itype_word(OP_SW, 9, 18, -4));
		emit(itype_word(OP_LW, 20, 18, 8));
		emit(itype_word(OP_LW, 21, 18, -4));
		pad(2);
		emit(rtype_word(FN_ADD, 22, 20, 21, 0));
		close_program();
		run_test("memory");
	endtask

	task automatic test_branch();
		prog.delete();
		emit(itype_word(OP_ADDI, 23, 0, 7));
		emit(itype_word(OP_ADDI, 24, 0, 7));
		emit(itype_word(OP_ADDI, 25, 0, 3));
		pad(2);
		emit(itype_word(OP_BEQ, 24, 23, 5)); // Taken, to word 11.
		emit(itype_word(OP_ADDI, 26, 0, 1));
		emit(itype_word(OP_ADDI, 27, 0, 2));
		emit(itype_word(OP_ADDI, 28, 0, 3));
		emit(itype_word(OP_ADDI, 29, 0, 4)); // Skipped.
		emit(itype_word(OP_ADDI, 30, 0, 5));
		emit(itype_word(OP_BEQ, 25, 23, 5)); // Not taken.
		emit(itype_word(OP_ADDI, 26, 0, 6));
		emit(itype_word(OP_ADDI, 27, 0, 7));
		emit(itype_word(OP_ADDI, 28, 0, 8));
		emit(itype_word(OP_ADDI, 29, 0, 9));
		emit(itype_word(OP_ADDI, 30, 0, 10));
		close_program();
		run_test("branches");
	endtask

	task automatic test_jump();
		prog.delete();
		emit(itype_word(OP_ADDI, 1, 0, 11));
		emit(jump_word(5));
		emit(itype_word(OP_ADDI, 2, 0, 22));
		emit(itype_word(OP_ADDI, 3, 0, 33));
		emit(itype_word(OP_ADDI, 4, 0, 44)); // Never retires.
		emit(itype_word(OP_ADDI, 5, 0, 55));
		close_program();
		run_test("jumps");
	endtask

	initial begin
		rst        = 1'b1;
		run        = 1'b0;
		load_valid = 1'b0;
		load_addr  = '0;
		load_data  = '0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		test_load_port();
		test_rtype();
		test_imm_shift();
		test_memory();
		test_branch();
		test_jump();
		$display("Errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
		if (mismatch_errors == 0 && other_errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== source/mips_pipeline.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mips_settings.svh"

module mips_pipeline (
	input  wire                      clk,
	input  wire                      rst,
	input  wire                      run,
	input  wire                      load_valid,
	output logic                     load_ready,
	input  wire [`MIPS_IMEM_AW-1:0]  load_addr,
	input  wire mips_pkg::word_t     load_data,
	output logic                     wb_valid,
	output mips_pkg::reg_idx_t       wb_reg,
	output mips_pkg::word_t          wb_data,
	output logic                     st_valid,
	output mips_pkg::word_t          st_addr,
	output mips_pkg::word_t          st_data
);

	import mips_pkg::*;

	logic  halt;
	logic  imem_we;
	word_t pc;
	word_t pc_next;
	word_t if_pc4;
	word_t if_instr;

	// IF/ID.
	logic  id_valid;
	word_t id_instr;
	word_t id_pc4;
	logic  id_reg_write;
	logic  id_reg_dst;
	logic  id_mem_to_reg;
	logic  id_mem_read;
	logic  id_mem_write;
	logic  id_is_branch;
	logic  id_is_jump;
	logic  id_alu_src;
	alu_class_e id_alu_class;
	word_t id_rs_data;
	word_t id_rt_data;

	// ID/EX.
	logic  ex_valid;
	logic  ex_reg_write;
	logic  ex_reg_dst;
	logic  ex_mem_to_reg;
	logic  ex_mem_read;
	logic  ex_mem_write;
	logic  ex_is_branch;
	logic  ex_is_jump;
	logic  ex_alu_src;
	alu_class_e ex_alu_class;
	word_t ex_pc4;
	word_t ex_rs_data;
	word_t ex_rt_data;
	word_t ex_imm;        // Also carries shamt and funct.
	logic [25:0] ex_jidx;
	reg_idx_t ex_rt;
	reg_idx_t ex_rd;
	word_t ex_alu_b;
	word_t ex_alu_result;
	logic  ex_zero;
	reg_idx_t ex_wr_reg;
	word_t ex_branch_target;
	word_t ex_jump_target;
	logic  jump_taken;

	// EX/MEM.
	logic  mem_valid;
	logic  mem_reg_write;
	logic  mem_mem_to_reg;
	logic  mem_mem_read;
	logic  mem_mem_write;
	logic  mem_is_branch;
	logic  mem_zero;
	word_t mem_branch_target;
	word_t mem_alu_result;
	word_t mem_rt_data;
	reg_idx_t mem_wr_reg;
	word_t dmem_rdata;
	logic  branch_taken;

	// MEM/WB.
	logic  wb_stage_valid;
	logic  wb_reg_write;
	logic  wb_mem_to_reg;
	word_t wb_load_data;
	word_t wb_alu_result;

	assign halt       = rst || !run;
	assign load_ready = !run;
	assign imem_we    = load_valid && load_ready;

	assign if_pc4 = pc + 32'd4;

	// Branch in MEM beats jump in EX.
	always_comb begin
		if (branch_taken) begin
			pc_next = mem_branch_target;
		end else if (jump_taken) begin
			pc_next = ex_jump_target;
		end else begin
			pc_next = if_pc4;
		end
	end

	always_ff @(posedge clk) begin
		if (halt) begin
			pc             <= '0;
			id_valid       <= 1'b0;
			ex_valid       <= 1'b0;
			mem_valid      <= 1'b0;
			wb_stage_valid <= 1'b0;
		end else begin
			pc             <= pc_next;
			id_valid       <= 1'b1;
			ex_valid       <= id_valid;
			mem_valid      <= ex_valid;
			wb_stage_valid <= mem_valid;
		end
	end

	word_mem #(.ADDR_W(`MIPS_IMEM_AW)) imem_i (
		.clk   (clk),
		.we    (imem_we),
		.waddr (load_addr),
		.wdata (load_data),
		.raddr (pc[`MIPS_IMEM_AW+1:2]),
		.rdata (if_instr)
	);

	always_ff @(posedge clk) begin
		id_instr <= if_instr;
		id_pc4   <= if_pc4;
	end

	main_control control_i (
		.opcode      (opcode_e'(id_instr[31:26])),
		.instr_valid (id_valid),
		.reg_write   (id_reg_write),
		.reg_dst     (id_reg_dst),
		.mem_to_reg  (id_mem_to_reg),
		.mem_read    (id_mem_read),
		.mem_write   (id_mem_write),
		.is_branch   (id_is_branch),
		.is_jump     (id_is_jump),
		.alu_src     (id_alu_src),
		.alu_class   (id_alu_class)
	);

	register_file regfile_i (
		.clk     (clk),
		.rst     (rst),
		.rs_idx  (id_instr[25:21]),
		.rt_idx  (id_instr[20:16]),
		.we      (wb_valid),
		.wr_idx  (wb_reg),
		.wr_data (wb_data),
		.rs_data (id_rs_data),
		.rt_data (id_rt_data)
	);

	always_ff @(posedge clk) begin
		ex_reg_write  <= id_reg_write;
		ex_reg_dst    <= id_reg_dst;
		ex_mem_to_reg <= id_mem_to_reg;
		ex_mem_read   <= id_mem_read;
		ex_mem_write  <= id_mem_write;
		ex_is_branch  <= id_is_branch;
		ex_is_jump    <= id_is_jump;
		ex_alu_src    <= id_alu_src;
		ex_alu_class  <= id_alu_class;
		ex_pc4        <= id_pc4;
		ex_rs_data    <= id_rs_data;
		ex_rt_data    <= id_rt_data;
		ex_imm        <= {{16{id_instr[15]}}, id_instr[15:0]}; // Sign extended.
		ex_jidx       <= id_instr[25:0];
		ex_rt         <= id_instr[20:16];
		ex_rd         <= id_instr[15:11];
	end

	assign ex_alu_b         = ex_alu_src ? ex_imm : ex_rt_data;
	assign ex_wr_reg        = ex_reg_dst ? ex_rd : ex_rt;
	assign ex_branch_target = ex_pc4 + (ex_imm << 2);
	assign ex_jump_target   = {ex_pc4[31:28], ex_jidx, 2'b00};
	assign jump_taken       = ex_valid && ex_is_jump; // Two delay slots.

	alu alu_i (
		.alu_class (ex_alu_class),
		.funct     (ex_imm[5:0]),
		.shamt     (ex_imm[10:6]),
		.a         (ex_rs_data),
		.b         (ex_alu_b),
		.result    (ex_alu_result),
		.zero      (ex_zero)
	);

	always_ff @(posedge clk) begin
		mem_reg_write     <= ex_reg_write;
		mem_mem_to_reg    <= ex_mem_to_reg;
		mem_mem_read      <= ex_mem_read;
		mem_mem_write     <= ex_mem_write;
		mem_is_branch     <= ex_is_branch;
		mem_zero          <= ex_zero;
		mem_branch_target <= ex_branch_target;
		mem_alu_result    <= ex_alu_result;
		mem_rt_data       <= ex_rt_data;
		mem_wr_reg        <= ex_wr_reg;
	end

	assign branch_taken = mem_valid && mem_is_branch && mem_zero; // Three delay slots.

	word_mem #(.ADDR_W(`MIPS_DMEM_AW)) dmem_i (
		.clk   (clk),
		.we    (st_valid),
		.waddr (mem_alu_result[`MIPS_DMEM_AW+1:2]),
		.wdata (mem_rt_data),
		.raddr (mem_alu_result[`MIPS_DMEM_AW+1:2]),
		.rdata (dmem_rdata)
	);

	assign st_valid = mem_valid && mem_mem_write;
	assign st_addr  = mem_alu_result;
	assign st_data  = mem_rt_data;

	always_ff @(posedge clk) begin
		wb_reg_write  <= mem_reg_write;
		wb_mem_to_reg <= mem_mem_to_reg;
		wb_alu_result <= mem_alu_result;
		wb_reg        <= mem_wr_reg;
		if (mem_mem_read) begin
			wb_load_data <= dmem_rdata; // Captured only for loads.
		end
	end

	assign wb_data  = wb_mem_to_reg ? wb_load_data : wb_alu_result;
	assign wb_valid = wb_stage_valid && wb_reg_write && (wb_reg != '0);

	// Data memory drops the two low address bits.
	aligned_data_access: assert property (@(posedge clk) disable iff (rst)
		(mem_valid && (mem_mem_read || mem_mem_write)) |-> mem_alu_result[1:0] == 2'b00)
		else $error("mips_pipeline: unaligned data access at %h", mem_alu_result);

endmodule

`default_nettype wire

// ==== source/alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu (
	input  wire mips_pkg::alu_class_e alu_class,
	input  wire [5:0]                 funct,
	input  wire [4:0]                 shamt,
	input  wire mips_pkg::word_t      a,
	input  wire mips_pkg::word_t      b,
	output mips_pkg::word_t           result,
	output logic                      zero
);

	import mips_pkg::*;

	alu_op_e op;

	// Class from the decoder, funct only for R-type.
	always_comb begin
		case (alu_class)
			ALU_CLASS_ADD: op = ALU_ADD;
			ALU_CLASS_SUB: op = ALU_SUB;
			default: begin
				case (funct_e'(funct))
					FN_ADD:  op = ALU_ADD;
					FN_SUB:  op = ALU_SUB;
					FN_AND:  op = ALU_AND;
					FN_OR:   op = ALU_OR;
					FN_SLT:  op = ALU_SLT;
					FN_SLL:  op = ALU_SLL;
					FN_SRL:  op = ALU_SRL;
					default: op = ALU_ADD; // Unsupported funct acts as add.
				endcase
			end
		endcase
	end

	always_comb begin
		case (op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_SLT: result = word_t'($signed(a) < $signed(b));
			ALU_SLL: result = b << shamt;  // Shifts act on rt.
			ALU_SRL: result = b >> shamt;  // Logical, zero fill.
			default: result = '0;
		endcase
	end

	// Equal operands for beq.
	assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== source/main_control.sv ====
`timescale 1ns/10ps
`default_nettype none

module main_control (
	input  wire mips_pkg::opcode_e opcode,
	input  wire                    instr_valid,
	output logic                   reg_write,
	output logic                   reg_dst,
	output logic                   mem_to_reg,
	output logic                   mem_read,
	output logic                   mem_write,
	output logic                   is_branch,
	output logic                   is_jump,
	output logic                   alu_src,
	output mips_pkg::alu_class_e   alu_class
);

	import mips_pkg::*;

	logic known_op;

	always_comb begin
		reg_write  = 1'b0;
		reg_dst    = 1'b0; // rt is the destination unless R-type.
		mem_to_reg = 1'b0;
		mem_read   = 1'b0;
		mem_write  = 1'b0;
		is_branch  = 1'b0;
		is_jump    = 1'b0;
		alu_src    = 1'b0;
		alu_class  = ALU_CLASS_ADD;
		known_op   = 1'b1;
		case (opcode)
			OP_RTYPE: begin
				reg_write = 1'b1;
				reg_dst   = 1'b1;
				alu_class = ALU_CLASS_FUNCT;
			end
			OP_ADDI: begin
				reg_write = 1'b1;
				alu_src   = 1'b1;
			end
			OP_LW: begin
				reg_write  = 1'b1;
				mem_to_reg = 1'b1;
				mem_read   = 1'b1;
				alu_src    = 1'b1; // Base plus offset.
			end
			OP_SW: begin
				mem_write = 1'b1;
				alu_src   = 1'b1;
			end
			OP_BEQ: begin
				is_branch = 1'b1;
				alu_class = ALU_CLASS_SUB;
			end
			OP_J:    is_jump  = 1'b1;
			default: known_op = 1'b0; // Falls through as a no-op.
		endcase

		// Bubbles keep their selects but lose every side effect.
		if (!instr_valid) begin
			reg_write = 1'b0;
			mem_read  = 1'b0;
			mem_write = 1'b0;
			is_branch = 1'b0;
			is_jump   = 1'b0;
		end
	end

	always_comb begin
		if (instr_valid) begin
			unknown_opcode: assert final (known_op)
				else $error("main_control: unknown opcode %b", opcode);
		end
	end

endmodule

`default_nettype wire

// ==== source/register_file.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mips_settings.svh"

module register_file (
	input  wire                     clk,
	input  wire                     rst,
	input  wire mips_pkg::reg_idx_t rs_idx,
	input  wire mips_pkg::reg_idx_t rt_idx,
	input  wire                     we,
	input  wire mips_pkg::reg_idx_t wr_idx,
	input  wire mips_pkg::word_t    wr_data,
	output mips_pkg::word_t         rs_data,
	output mips_pkg::word_t         rt_data
);

	import mips_pkg::*;

	word_t regs [1 << `MIPS_REG_AW];
	logic  wr_live; // Write that really lands.

	assign wr_live = we && (wr_idx != '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			regs <= '{default: '0};
		end else if (wr_live) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// WB and ID share a cycle, so the value being written is passed straight through.
	assign rs_data = (wr_live && wr_idx == rs_idx) ? wr_data : regs[rs_idx];
	assign rt_data = (wr_live && wr_idx == rt_idx) ? wr_data : regs[rt_idx];

	zero_reg_reads_zero: assert property (@(posedge clk) disable iff (rst)
		(rs_idx == '0 |-> rs_data == '0) and (rt_idx == '0 |-> rt_data == '0))
		else $error("register_file: r0 read nonzero");

endmodule

`default_nettype wire

// ==== source/word_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mips_settings.svh"

module word_mem #(
	parameter int ADDR_W = `MIPS_DMEM_AW
) (
	input  wire                  clk,
	input  wire                  we,
	input  wire [ADDR_W-1:0]     waddr,
	input  wire mips_pkg::word_t wdata,
	input  wire [ADDR_W-1:0]     raddr,
	output mips_pkg::word_t      rdata
);

	import mips_pkg::*;

	localparam int DEPTH = 1 << ADDR_W;

	// Storage only. Contents come from the load port or stores.
	word_t mem [DEPTH];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// Read is combinational so fetch and load complete in their own stage.
	assign rdata = mem[raddr];

endmodule

`default_nettype wire

// ==== source/mips_pkg.sv ====
`default_nettype none

`include "mips_settings.svh"

package mips_pkg;

	typedef logic [`MIPS_XLEN-1:0] word_t;
	typedef logic [`MIPS_REG_AW-1:0] reg_idx_t;

	// Primary opcode field, bits 31:26.
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_J     = 6'h02,
		OP_BEQ   = 6'h04,
		OP_ADDI  = 6'h08,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} opcode_e;

	// R-type funct field, bits 5:0.
	typedef enum logic [5:0] {
		FN_SLL = 6'h00,
		FN_SRL = 6'h02,
		FN_ADD = 6'h20,
		FN_SUB = 6'h22,
		FN_AND = 6'h24,
		FN_OR  = 6'h25,
		FN_SLT = 6'h2a
	} funct_e;

	// What the decoder asks of the ALU.
	typedef enum logic [1:0] {
		ALU_CLASS_ADD   = 2'b00, // Address and immediate arithmetic.
		ALU_CLASS_SUB   = 2'b01, // Compare for beq.
		ALU_CLASS_FUNCT = 2'b10  // Operation from funct.
	} alu_class_e;

	typedef enum logic [3:0] {
		ALU_AND = 4'd0,
		ALU_OR  = 4'd1,
		ALU_ADD = 4'd2,
		ALU_SUB = 4'd6,
		ALU_SLT = 4'd7,
		ALU_SLL = 4'd8,
		ALU_SRL = 4'd9
	} alu_op_e;

endpackage

`default_nettype wire

// ==== source/mips_settings.svh ====
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// Data word and byte address width.
`define MIPS_XLEN 32

// Instruction memory word address bits (64 words).
`define MIPS_IMEM_AW 6

// Data memory word address bits (64 words).
`define MIPS_DMEM_AW 6

// Register index width.
`define MIPS_REG_AW 5

`endif
